//--- icache_pkg.sv
// geometry is fixed at 128 bytes, 2 ways and 16-byte blocks of 32-bit words with 32-bit addresses
package icache_pkg;

    // cache geometry
    localparam int ICACHE_BYTES = 128;
    localparam int BLOCK_BYTES  = 16;
    localparam int WAYS         = 2;
    localparam int NUM_SETS     = ICACHE_BYTES / (BLOCK_BYTES * WAYS);
    localparam int BEATS        = BLOCK_BYTES / 4;      // 32-bit words per block

    // address split: tag | index | offset
    localparam int OFFSET_W = $clog2(BLOCK_BYTES);
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;
    localparam int BEAT_W   = $clog2(BEATS);

    // request queue depth, also the credits held by the core after reset
    localparam int REQ_CREDITS = 2;
    localparam int QPTR_W      = $clog2(REQ_CREDITS);
    localparam int QCNT_W      = $clog2(REQ_CREDITS + 1);

    // fixed AXI burst shape, one block per burst
    localparam logic [7:0] AR_LEN   = 8'(BEATS - 1);
    localparam logic [2:0] AR_SIZE  = 3'b010;          // 4 bytes per beat
    localparam logic [1:0] AR_BURST = 2'b01;           // INCR

    typedef logic [31:0]              word_t;
    typedef logic [31:0]              addr_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       set_idx_t;
    typedef logic [$clog2(WAYS)-1:0]  way_t;
    typedef logic [BEAT_W-1:0]        beat_t;
    typedef word_t [BEATS-1:0]        block_t;          // indexed by beat number

    typedef struct packed {
        addr_t addr;
        logic  fence;      // invalidate all, addr ignored
    } fetch_req_t;

endpackage

//--- fetch_req_if.sv
// a transfer happens only on a cycle where valid and ready are both high
`timescale 1ns/1ps

interface fetch_req_if import icache_pkg::*; ();

    logic       valid;   // head of queue present
    logic       ready;   // cache idle
    fetch_req_t req;

    modport source (
        output valid,
        output req,
        input  ready
    );

    modport sink (
        input  valid,
        input  req,
        output ready
    );

endinterface

//--- refill_if.sv
// only one refill may be in flight and start must carry a block-aligned address
`timescale 1ns/1ps

interface refill_if import icache_pkg::*; ();

    logic   start;   // one-cycle pulse
    addr_t  addr;    // block aligned
    logic   done;    // one-cycle pulse, data and error valid with it
    block_t data;
    logic   error;   // any beat came back with nonzero rresp

    modport requester (
        output start,
        output addr,
        input  done,
        input  data,
        input  error
    );

    modport responder (
        input  start,
        input  addr,
        output done,
        output data,
        output error
    );

endinterface

//--- fetch_port.sv
// the core must hold a credit for each request; a request into a full queue is dropped
`timescale 1ns/1ps

module fetch_port import icache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  addr_t       req_addr,
    input  logic        req_fence,
    output logic        req_credit,
    fetch_req_if.source out
);

    fetch_req_t        queue [REQ_CREDITS];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              full;
    logic              push;
    logic              pop;

    // circular pointer step, depth need not be a power of two
    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
        return (p == QPTR_W'(REQ_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == QCNT_W'(REQ_CREDITS));
    assign push = req_valid && !full;   // never overwrite a queued entry
    assign pop  = out.valid && out.ready;

    assign out.valid  = (count != '0);
    assign out.req    = queue[rd_ptr];
    assign req_credit = pop;            // credit goes back in the handover cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + QCNT_W'(push) - QCNT_W'(pop);
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (push)
            queue[wr_ptr] <= '{addr: req_addr, fence: req_fence};
    end

endmodule

//--- icache_core.sv
// one miss at a time and no stall on responses; a fence drops every line and answers nothing
`timescale 1ns/1ps

module icache_core import icache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    fetch_req_if.sink   in,
    refill_if.requester refill,
    output logic        rsp_valid,
    output word_t       rsp_inst,
    output logic        rsp_error
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        RESPOND
    } state_t;

    state_t          state;
    fetch_req_t      req_q;                  // request being served
    tag_t            tag_mem   [NUM_SETS][WAYS];
    block_t          data_mem  [NUM_SETS][WAYS];
    logic [WAYS-1:0] valid_mem [NUM_SETS];
    way_t            lru_mem   [NUM_SETS][WAYS];
    word_t           fill_word;              // answer after a refill
    logic            fill_err;

    tag_t     req_tag;
    set_idx_t req_idx;
    beat_t    req_beat;
    logic     hit;
    way_t     hit_way;
    logic     found_invalid;
    way_t     victim;
    logic     lookup_hit;
    logic     fill_ok;
    logic     use_en;
    way_t     use_way;

    assign req_tag  = req_q.addr[31 -: TAG_W];
    assign req_idx  = req_q.addr[OFFSET_W +: INDEX_W];
    assign req_beat = req_q.addr[OFFSET_W-1 -: BEAT_W];

    // tag compare across the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_mem[req_idx][w] && tag_mem[req_idx][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // victim: highest invalid way first, else smallest counter with ties to the lower way
    always_comb begin
        found_invalid = 1'b0;
        victim        = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!valid_mem[req_idx][w]) begin
                found_invalid = 1'b1;
                victim        = way_t'(w);
            end
        end
        if (!found_invalid) begin
            for (int w = 1; w < WAYS; w++) begin
                if (lru_mem[req_idx][w] < lru_mem[req_idx][victim])
                    victim = way_t'(w);
            end
        end
    end

    assign in.ready   = (state == IDLE);
    assign lookup_hit = (state == LOOKUP) && !req_q.fence && hit;
    assign fill_ok    = (state == MISS_WAIT) && refill.done && !refill.error;
    assign use_en     = lookup_hit || fill_ok;
    assign use_way    = lookup_hit ? hit_way : victim;

    assign refill.start = (state == LOOKUP) && !req_q.fence && !hit;
    assign refill.addr  = {req_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign rsp_valid = lookup_hit || (state == RESPOND);
    assign rsp_inst  = (state == RESPOND) ? fill_word : data_mem[req_idx][hit_way][req_beat];
    assign rsp_error = (state == RESPOND) && fill_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (in.valid) state <= LOOKUP;
                LOOKUP:    state <= refill.start ? MISS_WAIT : IDLE;
                MISS_WAIT: if (refill.done) state <= RESPOND;
                RESPOND:   state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // valid bits and LRU counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= '0;
                for (int w = 0; w < WAYS; w++)
                    lru_mem[s][w] <= way_t'(w);
            end
        end else if (state == LOOKUP && req_q.fence) begin
            for (int s = 0; s < NUM_SETS; s++)
                valid_mem[s] <= '0;
        end else if (use_en) begin
            if (fill_ok)
                valid_mem[req_idx][victim] <= 1'b1;
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == use_way)
                    lru_mem[req_idx][w] <= way_t'(WAYS - 1);     // most recent
                else if (lru_mem[req_idx][w] != '0)
                    lru_mem[req_idx][w] <= lru_mem[req_idx][w] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready)
            req_q <= in.req;
        if (refill.done) begin
            fill_err  <= refill.error;
            fill_word <= refill.error ? '0 : refill.data[req_beat];
        end
        if (fill_ok) begin                   // failed bursts leave the set alone
            tag_mem[req_idx][victim]  <= req_tag;
            data_mem[req_idx][victim] <= refill.data;
        end
    end

endmodule

//--- axi_refill.sv
// single outstanding INCR burst of BEATS words with no IDs; any nonzero rresp flags the block
`timescale 1ns/1ps

module axi_refill import icache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    refill_if.responder req,
    output addr_t       araddr,
    output logic        arvalid,
    input  logic        arready,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  word_t       rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast
);

    beat_t  beat_cnt;
    block_t data_q;
    logic   err_q;
    logic   done_q;
    logic   ar_fire;
    logic   r_fire;

    assign arlen   = AR_LEN;
    assign arsize  = AR_SIZE;
    assign arburst = AR_BURST;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    assign req.done  = done_q;
    assign req.data  = data_q;
    assign req.error = err_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            done_q   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            done_q <= r_fire && rlast;       // one cycle after the last beat
            if (req.start)
                arvalid <= 1'b1;
            else if (ar_fire)
                arvalid <= 1'b0;
            if (ar_fire) begin
                rready   <= 1'b1;
                beat_cnt <= '0;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (rlast)
                    rready <= 1'b0;
            end
        end
    end

    // burst payload
    always_ff @(posedge clk) begin
        if (req.start)
            araddr <= req.addr;
        if (ar_fire)
            err_q <= 1'b0;
        else if (r_fire)
            err_q <= err_q | (|rresp);
        if (r_fire)
            data_q[beat_cnt] <= rdata;
    end

endmodule

//--- icache_top.sv
// the core must respect req_credit and accept every response; the AXI side is read only
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // core side
    input  logic       req_valid,
    input  addr_t      req_addr,
    input  logic       req_fence,
    output logic       req_credit,
    output logic       rsp_valid,
    output word_t      rsp_inst,
    output logic       rsp_error,
    // AXI read master
    output addr_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    input  logic       rlast
);

    fetch_req_if fq ();
    refill_if    rf ();

    fetch_port i_fetch (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_fence  (req_fence),
        .req_credit (req_credit),
        .out        (fq.source)
    );

    icache_core i_core (
        .clk       (clk),
        .reset     (reset),
        .in        (fq.sink),
        .refill    (rf.requester),
        .rsp_valid (rsp_valid),
        .rsp_inst  (rsp_inst),
        .rsp_error (rsp_error)
    );

    axi_refill i_refill (
        .clk     (clk),
        .reset   (reset),
        .req     (rf.responder),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

endmodule

//--- tb_clock_gen.sv
// free-running 40 ns clock; reset is released on a falling edge after two rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;    // held for two full cycles
    end

endmodule

//--- icache_checker.sv
// assumes a core that spends credits only while it holds them; bound into icache_top by name
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       req_valid,
    input logic       req_credit,
    input logic       rsp_valid,
    input word_t      rsp_inst,
    input logic       rsp_error,
    input addr_t      araddr,
    input logic       arvalid,
    input logic       arready,
    input logic [7:0] arlen,
    input logic [2:0] arsize,
    input logic [1:0] arburst,
    input logic       rvalid,
    input logic       rready,
    input logic       rlast
);

    int fail_count = 0;
    int outstanding;     // requests sent minus credits returned

    always @(posedge clk) begin
        if (reset)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(req_valid) - int'(req_credit);
    end

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> outstanding < REQ_CREDITS)
        else begin $error("request sent with no credit left"); fail_count++; end

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin $error("AR dropped or changed before arready"); fail_count++; end

    ar_shape: assert property (@(posedge clk) disable iff (reset)
        arvalid |-> arlen == 8'd3 && arsize == 3'b010 && arburst == 2'b01)
        else begin $error("AR burst is not four INCR beats of 4 bytes"); fail_count++; end

    r_end: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready && rlast |=> !rready)
        else begin $error("rready still high after the rlast beat"); fail_count++; end

    err_word: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && rsp_error |-> rsp_inst == '0)
        else begin $error("error response carries a nonzero word"); fail_count++; end

    reset_quiet: assert property (@(posedge clk)
        reset |=> !req_credit && !rsp_valid && !arvalid && !rready)
        else begin $error("output active right after reset"); fail_count++; end

endmodule

bind icache_top icache_checker i_checker (.*);

//--- tb_icache.sv
// reads icache_cases.txt from the project root; the AXI model serves one burst at a time
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

    typedef struct packed {
        logic [7:0] op;      // F fetch, I fence
        addr_t      addr;
        word_t      word;
        logic       miss;
        logic       err;
    } case_t;

    logic       clk;
    logic       reset;
    logic       req_valid;
    addr_t      req_addr;
    logic       req_fence;
    logic       req_credit;
    logic       rsp_valid;
    word_t      rsp_inst;
    logic       rsp_error;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       rvalid;
    logic       rready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;

    case_t  cases [$];
    case_t  expect_q [$];          // fetches still waiting for a response
    integer seed = 32'h4c14;
    logic   go;
    int     n_cases = 0;
    int     n_sent = 0;
    int     n_rsp = 0;
    int     n_rsp_expected = 0;
    int     credits = REQ_CREDITS;
    int     credit_pulses = 0;
    int     ar_seen = 0;           // AR handshakes since the last response

    tb_clock_gen i_clk (.clk(clk), .reset(reset));

    icache_top i_dut (.*);

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic abort_run(string why);
        $display("ERROR time=%0t %s", $time, why);
        stop_run();
    endtask

    task automatic check_word(string sig, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, sig, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string sig, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b exp=%b", $time, sig, got, exp);
            stop_run();
        end
    endtask

    task automatic check_miss(int got, int exp);
        if (got != exp) begin
            $display("MISMATCH time=%0t AR handshakes got=%0d exp=%0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(string sig, int got, int exp);
        if (got != exp) begin
            $display("MISMATCH time=%0t %s got=%0d exp=%0d", $time, sig, got, exp);
            stop_run();
        end
    endtask

    task automatic load_cases();
        int         fd;
        string      line;
        case_t      c;
        logic [7:0] op;
        addr_t      addr;
        word_t      word;
        int         miss_i;
        int         err_i;
        fd = $fopen("icache_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open icache_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%c %h %h %d %d", op, addr, word, miss_i, err_i) == 5) begin
                c.op   = op;
                c.addr = addr;
                c.word = word;
                c.miss = miss_i[0];
                c.err  = err_i[0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // core side, spends a credit per request and counts returned ones
    initial begin : driver
        case_t c;
        req_valid = 1'b0;
        req_addr  = '0;
        req_fence = 1'b0;
        wait (go);
        forever begin
            @(negedge clk);
            req_valid = 1'b0;
            if (credits > 0 && n_sent < n_cases) begin
                c         = cases[n_sent];
                req_valid = 1'b1;
                req_addr  = c.addr;
                req_fence = (c.op == "I");
                if (c.op == "F")
                    expect_q.push_back(c);
                credits--;
                n_sent++;
            end
            if (req_credit) begin      // usable from the next request on
                credits++;
                credit_pulses++;
            end
            if (credits > REQ_CREDITS)
                abort_run("more credits returned than requests sent");
        end
    end

    // AXI slave, random AR delay and beat gaps
    initial begin : memory
        addr_t base;
        int    gap;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        rlast   = 1'b0;
        wait (go);
        forever begin
            @(negedge clk);
            if (arvalid) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
                base    = araddr;
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                for (int b = 0; b < BEATS; b++) begin
                    gap = $unsigned($random(seed)) % 2;
                    repeat (gap) @(negedge clk);
                    rvalid = 1'b1;
                    rdata  = (base + addr_t'(4 * b)) ^ 32'h1357_9bdf;
                    rresp  = (base >= 32'h0000_f000) ? 2'b10 : 2'b00;    // SLVERR region
                    rlast  = (b == BEATS - 1);
                    while (!rready)            // beat held until the master takes it
                        @(negedge clk);
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : monitor
        case_t exp;
        if (go) begin
            if (i_dut.i_checker.fail_count != 0)
                abort_run("a bound assertion in icache_checker failed");
            if (arvalid && arready)
                ar_seen++;
            if (rsp_valid) begin
                if (expect_q.size() == 0) begin
                    abort_run("response arrived with no fetch outstanding");
                end else begin
                    exp = expect_q.pop_front();    // in request order
                    check_word("rsp_inst", rsp_inst, exp.word);
                    check_flag("rsp_error", rsp_error, exp.err);
                    check_miss(ar_seen, int'(exp.miss));
                    ar_seen = 0;
                    n_rsp++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (n_cases > 0);
        #(n_cases * 400 + 2000);
        abort_run("watchdog expired before all responses arrived");
    end

    initial begin : main
        go = 1'b0;
        load_cases();
        n_cases = cases.size();
        if (n_cases == 0)
            abort_run("no cases found in icache_cases.txt");
        foreach (cases[i])
            if (cases[i].op == "F")
                n_rsp_expected++;
        @(negedge reset);
        @(posedge clk);
        go = 1'b1;
        wait (n_sent == n_cases && n_rsp == n_rsp_expected);
        repeat (4) @(posedge clk);
        check_count("req_credit pulses", credit_pulses, n_sent);
        if (ar_seen != 0) begin
            abort_run("AR burst issued after the last response");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- icache_cases.txt
# op addr word miss err : F fetch or I fence, hex byte address, hex expected word
# then expected miss flag (one AR burst) and expected error flag, all set 0 unless noted
F 00000104 13579adb 1 0
F 00000108 13579ad7 0 0
F 0000010c 13579ad3 0 0
F 00000204 135799db 1 0
F 00000100 13579adf 0 0
F 00000308 135798d7 1 0
F 0000010c 13579ad3 0 0
F 00000200 135799df 1 0
F 00000304 135798db 1 0
F 00000014 13579bcb 1 0
F 00000018 13579bc7 0 0
I 00000000 00000000 0 0
F 00000204 135799db 1 0
F 00000304 135798db 1 0
F 00000014 13579bcb 1 0
F 00000208 135799d7 0 0
F 0000f004 00000000 1 1
F 0000f004 00000000 1 1
F 0000030c 135798d3 0 0
F 0000020c 135799d3 0 0

//--- tb.f
icache_pkg.sv
fetch_req_if.sv
refill_if.sv
fetch_port.sv
icache_core.sv
axi_refill.sv
icache_top.sv
tb_clock_gen.sv
icache_checker.sv
tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f tb.f -o sim_icache \
    && ./obj_dir/sim_icache | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
